/* bench/matmul_vectors.txt */
# x00 x01 x10 x11 | y00 y10 y01 y11 (Y column-wise) | r00 r01 r10 r11
# Elements 8-bit signed with 1 fraction bit, results 12-bit signed integers
02 04 06 08 02 04 06 08 005 00B 00B 019
02 00 00 02 0A 14 1E 28 005 00F 00A 014
FE 04 06 F8 02 FC FA 08 FFB 00B 00B FE7
01 00 00 01 01 02 03 04 000 001 001 001
01 00 00 01 FF FE FD FC 000 FFF 000 FFF
01 00 00 01 05 06 FB FA 001 FFF 002 FFF
01 00 00 01 0A F6 0E F2 003 004 FFE FFD
7F 7F 7F 7F 7F 7F 7F 7F 7FF 7FF 7FF 7FF
80 80 80 80 7F 7F 7F 7F 800 800 800 800
80 80 80 80 80 80 80 80 7FF 7FF 7FF 7FF
7F 7F 80 80 7F 7F 80 80 7FF 800 800 7FF
40 00 00 40 7F 80 01 FF 7F0 010 800 FF0
03 05 F9 02 04 FD 06 09 FFF 010 FF8 FFA
10 20 30 F0 11 EF 22 01 FBC 090 110 194
0B 0D E5 1F 07 F3 19 E3 FE9 FE7 F6C E77
64 64 64 64 64 64 9C 9C 7FF 800 7FF 800
2D 2D 2D 2D 2D 2D D3 2D 3F5 000 3F5 000
01 00 00 01 7F 81 02 FE 020 001 FE0 000
00 00 00 00 12 34 56 78 000 000 000 000
FF FF FF FF FF FF FF FF 001 001 001 001
02 00 00 02 0C F4 07 F9 006 004 FFA FFD
7F 80 01 FF 03 01 02 05 03F FA0 001 FFF
08 08 08 08 03 03 03 03 00C 00C 00C 00C
05 03 07 02 09 04 08 06 00E 00F 012 011

/* bench/simple_matmul_tb.sv */
/*
  Testbench for the fixed-point matrix multiplier
  - clock, reset and vector file reader
  - X and Y drivers with random idle gaps, random out_ready
  - scoreboard, handshake and stall checks, burst latency check
  - watchdog sized from the number of vectors
*/

`timescale 1ns/1ns
`default_nettype none

`include "matmul_params.svh"

module simple_matmul_tb;

  localparam int NX       = `MATMUL_N * `MATMUL_M;
  localparam int NY       = `MATMUL_M * `MATMUL_K;
  localparam int NK       = `MATMUL_N * `MATMUL_K;
  localparam int CLK_HALF = 2;
  // Last vectors run back to back with out_ready held high
  localparam int BURST    = 8;
  // Samples from accepted input to first visible out_valid
  localparam int LATENCY  = 3;

  logic                    clk = 1'b0;
  logic                    reset;
  matmul_pkg::x_matrix_t   x_data;
  logic                    x_valid;
  logic                    x_ready;
  matmul_pkg::y_matrix_t   y_data;
  logic                    y_valid;
  logic                    y_ready;
  matmul_pkg::out_matrix_t out_data;
  logic                    out_valid;
  logic                    out_ready;

  // Vectors from file and the expected results in flight
  matmul_pkg::x_matrix_t   x_all[$];
  matmul_pkg::y_matrix_t   y_all[$];
  matmul_pkg::out_matrix_t exp_all[$];
  matmul_pkg::out_matrix_t exp_q[$];

  int          n_vec;
  int          n_rand;
  int          x_count;
  int          y_count;
  int          recv_count;
  int          cycle_cnt;
  int          after_reset;
  logic [31:0] lfsr;
  bit          loaded;
  bit          burst_mode;
  bit          burst_seen;
  int          burst_edge;
  // Output stall tracking
  logic                    stall_q;
  matmul_pkg::out_matrix_t held_q;

  simple_matmul DUT (
    .clk       (clk),
    .reset     (reset),
    .x_data    (x_data),
    .x_valid   (x_valid),
    .x_ready   (x_ready),
    .y_data    (y_data),
    .y_valid   (y_valid),
    .y_ready   (y_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    forever #CLK_HALF clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_next(lfsr);
      val  = (val << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("TB FAILED");
    $fatal(1, "run aborted");
  endtask

  // Each line holds X elements, Y elements and expected results in hex
  task automatic load_vectors();
    int                      fd;
    int                      cnt;
    string                   line;
    logic [31:0]             v[12];
    matmul_pkg::x_matrix_t   xm;
    matmul_pkg::y_matrix_t   ym;
    matmul_pkg::out_matrix_t em;
    fd = $fopen("bench/matmul_vectors.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open bench/matmul_vectors.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      cnt  = $fgets(line, fd);
      if (line.len() == 0 || line[0] == "#") begin
        continue;
      end
      cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", v[0], v[1], v[2], v[3],
                    v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11]);
      if (cnt <= 0) begin
        continue;
      end
      if (cnt != NX + NY + NK) begin
        abort_run("malformed line in vector file");
      end
      for (int k = 0; k < NX; k++) begin
        xm.elem[k] = v[k][`MATMUL_X_WIDTH-1:0];
      end
      for (int k = 0; k < NY; k++) begin
        ym.elem[k] = v[NX+k][`MATMUL_Y_WIDTH-1:0];
      end
      for (int k = 0; k < NK; k++) begin
        em.elem[k] = v[NX+NY+k][`MATMUL_OUT_WIDTH-1:0];
      end
      x_all.push_back(xm);
      y_all.push_back(ym);
      exp_all.push_back(em);
    end
    $fclose(fd);
    n_vec = x_all.size();
    if (n_vec <= BURST) begin
      abort_run("too few vectors in file");
    end
  endtask

  // Called just after a rising edge and returns the same way
  task automatic drive_x(input int first, input int last, input bit gaps);
    int gap;
    for (int idx = first; idx <= last; idx++) begin
      gap = 0;
      if (gaps) begin
        take_bits(2, gap);
      end
      if (gap > 0) begin
        x_valid = 1'b0;
        repeat (gap) @(posedge clk);
        #1;
      end
      x_data  = x_all[idx];
      x_valid = 1'b1;
      do @(negedge clk); while (!x_ready);
      @(posedge clk);
      #1;
    end
    x_valid = 1'b0;
  endtask

  task automatic drive_y(input int first, input int last, input bit gaps);
    int gap;
    for (int idx = first; idx <= last; idx++) begin
      gap = 0;
      if (gaps) begin
        take_bits(2, gap);
      end
      if (gap > 0) begin
        y_valid = 1'b0;
        repeat (gap) @(posedge clk);
        #1;
      end
      y_data  = y_all[idx];
      y_valid = 1'b1;
      do @(negedge clk); while (!y_ready);
      @(posedge clk);
      #1;
    end
    y_valid = 1'b0;
  endtask

  // Random back-pressure with out_ready high about three quarters of the time
  initial begin
    int r;
    forever begin
      @(posedge clk);
      #1;
      if (burst_mode) begin
        out_ready = 1'b1;
      end else begin
        take_bits(2, r);
        out_ready = (r != 0);
      end
    end
  end

  // Sampled mid-cycle where inputs and registers are settled
  always @(negedge clk) begin
    matmul_pkg::out_matrix_t exp;
    if (reset) begin
      check_value("out_valid", 64'd0, {63'd0, out_valid});
      after_reset = 0;
      stall_q     = 1'b0;
    end else begin
      if (after_reset == 0) begin
        check_value("out_valid", 64'd0, {63'd0, out_valid});
      end
      after_reset++;
      // One side moves only together with the other
      check_value("y_valid && y_ready", {63'd0, x_valid && x_ready},
                  {63'd0, y_valid && y_ready});
      if (x_valid && x_ready) begin
        exp_q.push_back(exp_all[x_count]);
        x_count++;
      end
      if (y_valid && y_ready) begin
        y_count++;
      end
      // Held output under stall
      if (stall_q) begin
        check_value("out_valid", 64'd1, {63'd0, out_valid});
        for (int e = 0; e < NK; e++) begin
          check_value($sformatf("out_data[%0d]", e), {52'd0, held_q.elem[e]},
                      {52'd0, out_data.elem[e]});
        end
      end
      stall_q = out_valid && !out_ready;
      held_q  = out_data;
      // Burst latency and then one result per cycle
      if (burst_mode) begin
        if (!burst_seen && x_valid && x_ready) begin
          burst_seen = 1'b1;
          burst_edge = cycle_cnt;
        end else if (burst_seen && recv_count - n_rand < BURST) begin
          if (cycle_cnt < burst_edge + LATENCY) begin
            check_value("out_valid", 64'd0, {63'd0, out_valid});
          end else begin
            check_value("out_valid", 64'd1, {63'd0, out_valid});
          end
        end
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          abort_run("result appeared without a matching input");
        end
        exp = exp_q.pop_front();
        for (int e = 0; e < NK; e++) begin
          check_value($sformatf("out_data[%0d]", e), {52'd0, exp.elem[e]},
                      {52'd0, out_data.elem[e]});
        end
        recv_count++;
      end
    end
  end

  // Watchdog
  initial begin
    wait (loaded);
    repeat (n_vec * 40 + 100) @(posedge clk);
    abort_run("timeout: not all results received");
  end

  initial begin
    reset      = 1'b1;
    x_data     = '0;
    x_valid    = 1'b0;
    y_data     = '0;
    y_valid    = 1'b0;
    out_ready  = 1'b0;
    lfsr       = 32'h193db3c2;
    cycle_cnt  = 0;
    x_count    = 0;
    y_count    = 0;
    recv_count = 0;
    burst_mode = 1'b0;
    burst_seen = 1'b0;
    burst_edge = 0;
    stall_q    = 1'b0;
    loaded     = 1'b0;
    load_vectors();
    n_rand = n_vec - BURST;
    loaded = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    // Random gaps on both inputs and random back-pressure
    fork
      drive_x(0, n_rand - 1, 1'b1);
      drive_y(0, n_rand - 1, 1'b1);
    join
    wait (recv_count == n_rand);
    @(posedge clk);
    #1;
    burst_mode = 1'b1;
    @(posedge clk);
    #1;
    fork
      drive_x(n_rand, n_vec - 1, 1'b0);
      drive_y(n_rand, n_vec - 1, 1'b0);
    join
    wait (recv_count == n_vec);
    repeat (4) @(posedge clk);
    if (exp_q.size() == 0 && x_count == n_vec && y_count == n_vec) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("inputs and results do not match up at the end");
      $display("TB FAILED");
      $fatal(1, "run ended with pending items");
    end
  end

endmodule

`default_nettype wire

/* hdl/dot_product_array.sv */
/*
  Execute stage of the matrix multiplier
  - N x K signed dot products over M elements
  - stage 1 registers every product
  - stage 2 registers the sign-extended sums
  - both stages share one stall rule driven by acc_ready
*/

`timescale 1ns/1ns
`default_nettype none

`include "matmul_params.svh"

module dot_product_array (
  input  logic                    clk,
  input  logic                    reset,
  input  matmul_pkg::operands_t   op_data,
  input  logic                    op_valid,
  output logic                    op_ready,
  output matmul_pkg::acc_matrix_t acc_data,
  output logic                    acc_valid,
  input  logic                    acc_ready
);

  localparam int N = `MATMUL_N;
  localparam int M = `MATMUL_M;
  localparam int K = `MATMUL_K;
  // Full-precision product of one X and one Y element
  localparam int PROD_WIDTH = `MATMUL_X_WIDTH + `MATMUL_Y_WIDTH;

  logic s1_valid;
  logic s2_valid;
  logic s1_advance;
  logic s2_advance;

  // Product registers, one per (i, j, m)
  logic signed [PROD_WIDTH-1:0] prod_q [N][K][M];

  // A stage moves when empty or when its successor takes its item
  assign s2_advance = !s2_valid || acc_ready;
  assign s1_advance = !s1_valid || s2_advance;

  assign op_ready  = s1_advance;
  assign acc_valid = s2_valid;

  // Stage valid bits
  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (s1_advance) begin
        s1_valid <= op_valid;
      end
      if (s2_advance) begin
        s2_valid <= s1_valid;
      end
    end
  end

  for (genvar i = 0; i < N; i++) begin : g_row
    for (genvar j = 0; j < K; j++) begin : g_col

      matmul_pkg::acc_t sum;

      // Stage 1, row i of X times column j of Y, element by element
      always_ff @(posedge clk) begin
        if (s1_advance) begin
          for (int m = 0; m < M; m++) begin
            prod_q[i][j][m] <= op_data.row[i][m] * op_data.col[j][m];
          end
        end
      end

      // Sign-extend each product before adding
      always_comb begin
        sum = '0;
        for (int m = 0; m < M; m++) begin
          sum = sum + matmul_pkg::acc_t'(prod_q[i][j][m]);
        end
      end

      // Stage 2, accumulator for (i, j)
      always_ff @(posedge clk) begin
        if (s2_advance) begin
          acc_data.acc[i*K+j] <= sum;
        end
      end

    end
  end

  // Held result while downstream stalls
  a_acc_hold: assert property (
    @(posedge clk) disable iff (reset)
    acc_valid && !acc_ready |=> acc_valid && $stable(acc_data)
  ) else $error("dot_product_array: acc_data changed under stall");

endmodule

`default_nettype wire

/* hdl/matmul_params.svh */
/*
  Matrix multiplier dimensions and fixed-point formats
  - N x M by M x K operand shapes
  - X and Y element widths and fraction bits
  - accumulator and output formats
*/

`ifndef MATMUL_PARAMS_SVH
`define MATMUL_PARAMS_SVH

// Rows of X
`define MATMUL_N 2
// Inner dimension, columns of X and rows of Y
`define MATMUL_M 2
// Columns of Y
`define MATMUL_K 2

// X element format, signed
`define MATMUL_X_WIDTH 8
`define MATMUL_X_FRAC 1
// Y element format, signed
`define MATMUL_Y_WIDTH 8
`define MATMUL_Y_FRAC 1

// X_WIDTH + Y_WIDTH + clog2(M), no overflow over M products
`define MATMUL_ACC_WIDTH 17
// X_FRAC + Y_FRAC
`define MATMUL_ACC_FRAC 2

// Rounded and saturated result format
`define MATMUL_OUT_WIDTH 12
`define MATMUL_OUT_FRAC 0

`endif

/* hdl/matmul_pkg.sv */
/*
  Shared types of the matrix multiplier
  - signed element types for X, Y, accumulators and results
  - operand matrices, regrouped operands
  - accumulator and result matrices
*/

`default_nettype none

`include "matmul_params.svh"

package matmul_pkg;

  // Element types, all signed
  typedef logic signed [`MATMUL_X_WIDTH-1:0]   x_elem_t;
  typedef logic signed [`MATMUL_Y_WIDTH-1:0]   y_elem_t;
  typedef logic signed [`MATMUL_ACC_WIDTH-1:0] acc_t;
  typedef logic signed [`MATMUL_OUT_WIDTH-1:0] out_t;

  // X in row-wise order, element (i, m) at i*M+m
  typedef struct packed {
    x_elem_t [`MATMUL_N*`MATMUL_M-1:0] elem;
  } x_matrix_t;

  // Y in column-wise order, element (m, j) at j*M+m
  typedef struct packed {
    y_elem_t [`MATMUL_M*`MATMUL_K-1:0] elem;
  } y_matrix_t;

  // X rows next to Y columns, same inner index m
  typedef struct packed {
    x_elem_t [`MATMUL_N-1:0][`MATMUL_M-1:0] row;
    y_elem_t [`MATMUL_K-1:0][`MATMUL_M-1:0] col;
  } operands_t;

  // One accumulator per (i, j), index i*K+j
  typedef struct packed {
    acc_t [`MATMUL_N*`MATMUL_K-1:0] acc;
  } acc_matrix_t;

  // Results row-major, (i, j) at i*K+j
  typedef struct packed {
    out_t [`MATMUL_N*`MATMUL_K-1:0] elem;
  } out_matrix_t;

endpackage

`default_nettype wire

/* hdl/operand_join.sv */
/*
  Decode stage of the matrix multiplier
  - two-way valid/ready join of the X and Y streams
  - X split into row vectors, Y into column vectors
  - combinational join and regrouping with no latency
*/

`timescale 1ns/1ns
`default_nettype none

`include "matmul_params.svh"

module operand_join (
  input  logic                  clk,
  input  logic                  reset,
  input  matmul_pkg::x_matrix_t x_data,
  input  logic                  x_valid,
  output logic                  x_ready,
  input  matmul_pkg::y_matrix_t y_data,
  input  logic                  y_valid,
  output logic                  y_ready,
  output matmul_pkg::operands_t op_data,
  output logic                  op_valid,
  input  logic                  op_ready
);

  localparam int N = `MATMUL_N;
  localparam int M = `MATMUL_M;
  localparam int K = `MATMUL_K;

  // Both matrices needed before anything moves
  assign op_valid = x_valid && y_valid;
  // Each side consumed only together with the other
  assign x_ready = op_ready && y_valid;
  assign y_ready = op_ready && x_valid;

  // Regroup flat inputs
  always_comb begin
    // X rows are already contiguous in row-wise order
    for (int i = 0; i < N; i++) begin
      for (int m = 0; m < M; m++) begin
        op_data.row[i][m] = x_data.elem[i*M+m];
      end
    end
    // Y columns are contiguous since Y comes column-wise
    for (int j = 0; j < K; j++) begin
      for (int m = 0; m < M; m++) begin
        op_data.col[j][m] = y_data.elem[j*M+m];
      end
    end
  end

  // Stalled operands must stay put until taken
  a_op_hold: assert property (
    @(posedge clk) disable iff (reset)
    op_valid && !op_ready |=> op_valid && $stable(op_data)
  ) else $error("operand_join: op_data changed under stall");

endmodule

`default_nettype wire

/* hdl/output_round.sv */
/*
  Result stage of the matrix multiplier
  - round half toward positive infinity, ACC_FRAC to OUT_FRAC bits
  - saturation to the signed OUT_WIDTH range
  - one registered output stage with valid/ready
*/

`timescale 1ns/1ns
`default_nettype none

`include "matmul_params.svh"

module output_round (
  input  logic                    clk,
  input  logic                    reset,
  input  matmul_pkg::acc_matrix_t acc_data,
  input  logic                    acc_valid,
  output logic                    acc_ready,
  output matmul_pkg::out_matrix_t out_data,
  output logic                    out_valid,
  input  logic                    out_ready
);

  localparam int NK        = `MATMUL_N * `MATMUL_K;
  localparam int ACC_WIDTH = `MATMUL_ACC_WIDTH;
  localparam int OUT_WIDTH = `MATMUL_OUT_WIDTH;
  // Fraction bits dropped by the conversion
  localparam int SHIFT     = `MATMUL_ACC_FRAC - `MATMUL_OUT_FRAC;

  // One spare bit so the rounding add cannot wrap
  localparam logic signed [ACC_WIDTH:0] HALF    = (1 << SHIFT) >> 1;
  localparam logic signed [ACC_WIDTH:0] OUT_MAX = (1 <<< (OUT_WIDTH - 1)) - 1;
  localparam logic signed [ACC_WIDTH:0] OUT_MIN = -(1 <<< (OUT_WIDTH - 1));

  logic                    load;
  matmul_pkg::out_matrix_t rounded;

  // Round one accumulator and clamp it
  function automatic matmul_pkg::out_t round_sat(input matmul_pkg::acc_t a);
    logic signed [ACC_WIDTH:0] biased;
    logic signed [ACC_WIDTH:0] shifted;
    biased  = {a[ACC_WIDTH-1], a} + HALF;
    // Arithmetic shift, floor of the biased value
    shifted = biased >>> SHIFT;
    if (shifted > OUT_MAX) begin
      return OUT_MAX[OUT_WIDTH-1:0];
    end else if (shifted < OUT_MIN) begin
      return OUT_MIN[OUT_WIDTH-1:0];
    end
    return shifted[OUT_WIDTH-1:0];
  endfunction

  always_comb begin
    for (int e = 0; e < NK; e++) begin
      rounded.elem[e] = round_sat(acc_data.acc[e]);
    end
  end

  // Register empty or being read out
  assign load      = !out_valid || out_ready;
  assign acc_ready = load;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= acc_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out_data <= rounded;
    end
  end

  // Format sanity, no left shift supported
  initial begin
    a_frac_order: assert (`MATMUL_OUT_FRAC <= `MATMUL_ACC_FRAC)
      else $fatal(1, "output_round: OUT_FRAC exceeds ACC_FRAC");
  end

  // Output held until the consumer takes it
  a_out_hold: assert property (
    @(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_data)
  ) else $error("output_round: out_data changed under stall");

endmodule

`default_nettype wire

/* hdl/simple_matmul.sv */
/*
  Top level of the fixed-point matrix multiplier
  - operand_join, decode stage
  - dot_product_array, two pipeline stages
  - output_round, registered rounding stage
*/

`timescale 1ns/1ns
`default_nettype none

module simple_matmul (
  input  logic                    clk,
  input  logic                    reset,
  // X, row-wise
  input  matmul_pkg::x_matrix_t   x_data,
  input  logic                    x_valid,
  output logic                    x_ready,
  // Y, column-wise
  input  matmul_pkg::y_matrix_t   y_data,
  input  logic                    y_valid,
  output logic                    y_ready,
  // Result, row-major
  output matmul_pkg::out_matrix_t out_data,
  output logic                    out_valid,
  input  logic                    out_ready
);

  // Joined operands
  matmul_pkg::operands_t   op_data;
  logic                    op_valid;
  logic                    op_ready;

  // Raw accumulators
  matmul_pkg::acc_matrix_t acc_data;
  logic                    acc_valid;
  logic                    acc_ready;

  operand_join u_join (
    .clk      (clk),
    .reset    (reset),
    .x_data   (x_data),
    .x_valid  (x_valid),
    .x_ready  (x_ready),
    .y_data   (y_data),
    .y_valid  (y_valid),
    .y_ready  (y_ready),
    .op_data  (op_data),
    .op_valid (op_valid),
    .op_ready (op_ready)
  );

  dot_product_array u_dot (
    .clk       (clk),
    .reset     (reset),
    .op_data   (op_data),
    .op_valid  (op_valid),
    .op_ready  (op_ready),
    .acc_data  (acc_data),
    .acc_valid (acc_valid),
    .acc_ready (acc_ready)
  );

  output_round u_round (
    .clk       (clk),
    .reset     (reset),
    .acc_data  (acc_data),
    .acc_valid (acc_valid),
    .acc_ready (acc_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Compile and run the matrix multiplier testbench with Verilator.
# Run from the project root.

LOG=sim.log
TOP=simple_matmul_tb

verilator --binary --timing --assert \
  --top-module "$TOP" \
  -f simple_matmul.f \
  -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Pass message not found in $LOG"
  exit 1
fi

/* simple_matmul.f */
+incdir+hdl
hdl/matmul_pkg.sv
hdl/operand_join.sv
hdl/dot_product_array.sv
hdl/output_round.sv
hdl/simple_matmul.sv
bench/simple_matmul_tb.sv
